//--- Bender.yml
package:
  name: minicore

sources:
  # RTL, package first
  - miniCorePkg.sv
  - miniCoreRegFile.sv
  - miniCoreDecode.sv
  - miniCoreExe.sv
  - miniCoreResult.sv
  - miniCore.sv
  # Testbench
  - target: simulation
    files:
      - miniCoreTb.sv

//--- miniCore.f
miniCorePkg.sv
miniCoreRegFile.sv
miniCoreDecode.sv
miniCoreExe.sv
miniCoreResult.sv
miniCore.sv
miniCoreTb.sv

//--- miniCore.sv
`timescale 1ns/1ns
// miniCore top level
// Four-stage RV32I integer datapath, register file plus three stages
module miniCore
  import miniCorePkg::*;
(
  input  logic        Clock,
  input  logic        arstN,
  input  logic        Ready,
  input  logic        InstrValidQ101H,
  input  t_instr      InstrQ101H,
  input  logic [31:0] PcQ101H,
  output logic        BranchValidQ102H,
  output logic        BranchTakenQ102H,
  output logic [31:0] BranchTargetQ102H,
  output logic        DMemWrEnQ103H,
  output logic [31:0] DMemAddrQ103H,
  output logic [31:0] DMemWrDataQ103H,
  output logic        RegWrEnQ104H,
  output logic [4:0]  RegDstQ104H,
  output logic [31:0] RegWrDataQ104H
);

  // Q101H
  logic [4:0]  RegSrc1Q101H, RegSrc2Q101H;
  logic [31:0] PreRegRdData1Q101H, PreRegRdData2Q101H;
  // Q102H
  logic        ValidQ102H, IsBranchQ102H, IsJumpQ102H, IsJalrQ102H, IsStoreQ102H;
  logic        LuiQ102H, SelAluPcQ102H, SelAluImmQ102H, RegWrEnQ102H;
  t_aluOp      AluOpQ102H;
  t_branchOp   BranchOpQ102H;
  logic [4:0]  RegSrc1Q102H, RegSrc2Q102H, RegDstQ102H;
  logic [31:0] ImmediateQ102H, PcQ102H, PreRegRdData1Q102H, PreRegRdData2Q102H;
  // Q103H
  logic [31:0] ResultQ103H, StoreDataQ103H;
  logic        RegWrEnQ103H, StoreQ103H;
  logic [4:0]  RegDstQ103H;

  miniCoreRegFile miniCoreRegFile_inst (
    .Clock, .arstN, .Ready,
    .RegSrc1Q101H, .RegSrc2Q101H,
    .RegWrEnQ104H, .RegDstQ104H, .RegWrDataQ104H,
    .PreRegRdData1Q101H, .PreRegRdData2Q101H
  );

  miniCoreDecode miniCoreDecode_inst (
    .Clock, .arstN, .Ready,
    .InstrValidQ101H, .InstrQ101H, .PcQ101H,
    .PreRegRdData1Q101H, .PreRegRdData2Q101H,
    .RegSrc1Q101H, .RegSrc2Q101H,
    .ValidQ102H, .AluOpQ102H, .BranchOpQ102H,
    .IsBranchQ102H, .IsJumpQ102H, .IsJalrQ102H, .IsStoreQ102H,
    .LuiQ102H, .SelAluPcQ102H, .SelAluImmQ102H, .RegWrEnQ102H,
    .RegSrc1Q102H, .RegSrc2Q102H, .RegDstQ102H,
    .ImmediateQ102H, .PcQ102H, .PreRegRdData1Q102H, .PreRegRdData2Q102H
  );

  miniCoreExe miniCoreExe_inst (
    .Clock, .arstN, .Ready,
    .ValidQ102H, .AluOpQ102H, .BranchOpQ102H,
    .IsBranchQ102H, .IsJumpQ102H, .IsJalrQ102H, .IsStoreQ102H,
    .LuiQ102H, .SelAluPcQ102H, .SelAluImmQ102H, .RegWrEnQ102H,
    .RegSrc1Q102H, .RegSrc2Q102H, .RegDstQ102H,
    .ImmediateQ102H, .PcQ102H, .PreRegRdData1Q102H, .PreRegRdData2Q102H,
    .RegWrEnQ104H, .RegDstQ104H, .RegWrDataQ104H,
    .BranchValidQ102H, .BranchTakenQ102H, .BranchTargetQ102H,
    .ResultQ103H, .RegWrEnQ103H, .RegDstQ103H, .StoreQ103H,
    .DMemWrDataQ103H (StoreDataQ103H)
  );

  miniCoreResult miniCoreResult_inst (
    .Clock, .arstN, .Ready,
    .ResultQ103H, .RegWrEnQ103H, .RegDstQ103H, .StoreQ103H, .StoreDataQ103H,
    .DMemWrEnQ103H, .DMemAddrQ103H, .DMemWrDataQ103H,
    .RegWrEnQ104H, .RegDstQ104H, .RegWrDataQ104H
  );

endmodule

//--- miniCoreDecode.sv
`timescale 1ns/1ns
// miniCore decode stage
// Splits the Q101H word into its formats, builds immediate and control
// Registers everything into Q102H, unsupported words become bubbles
module miniCoreDecode
  import miniCorePkg::*;
(
  input  logic        Clock,
  input  logic        arstN,
  input  logic        Ready,
  input  logic        InstrValidQ101H,
  input  t_instr      InstrQ101H,
  input  logic [31:0] PcQ101H,
  input  logic [31:0] PreRegRdData1Q101H,
  input  logic [31:0] PreRegRdData2Q101H,
  output logic [4:0]  RegSrc1Q101H,
  output logic [4:0]  RegSrc2Q101H,
  output logic        ValidQ102H,
  output t_aluOp      AluOpQ102H,
  output t_branchOp   BranchOpQ102H,
  output logic        IsBranchQ102H,
  output logic        IsJumpQ102H,
  output logic        IsJalrQ102H,
  output logic        IsStoreQ102H,
  output logic        LuiQ102H,
  output logic        SelAluPcQ102H,
  output logic        SelAluImmQ102H,
  output logic        RegWrEnQ102H,
  output logic [4:0]  RegSrc1Q102H,
  output logic [4:0]  RegSrc2Q102H,
  output logic [4:0]  RegDstQ102H,
  output logic [31:0] ImmediateQ102H,
  output logic [31:0] PcQ102H,
  output logic [31:0] PreRegRdData1Q102H,
  output logic [31:0] PreRegRdData2Q102H
);

  logic [31:0] ImmIQ101H, ImmSQ101H, ImmBQ101H, ImmUQ101H, ImmJQ101H;
  logic [31:0] ImmediateQ101H;
  logic        SupportedQ101H;
  t_aluOp      AluOpQ101H;
  logic        IsBranchQ101H, IsJumpQ101H, IsJalrQ101H, IsStoreQ101H;
  logic        LuiQ101H, SelAluPcQ101H, SelAluImmQ101H, RegWrEnQ101H;

  assign RegSrc1Q101H = InstrQ101H.r.rs1;
  assign RegSrc2Q101H = InstrQ101H.r.rs2;

  // ========================================
  // Immediates, one per format
  // ========================================
  assign ImmIQ101H = {{20{InstrQ101H.i.imm11_0[11]}}, InstrQ101H.i.imm11_0};
  assign ImmSQ101H = {{20{InstrQ101H.s.imm11_5[6]}}, InstrQ101H.s.imm11_5, InstrQ101H.s.imm4_0};
  assign ImmBQ101H = {{20{InstrQ101H.b.imm12}}, InstrQ101H.b.imm11, InstrQ101H.b.imm10_5,
                      InstrQ101H.b.imm4_1, 1'b0};
  assign ImmUQ101H = {InstrQ101H.u.imm31_12, 12'b0};
  assign ImmJQ101H = {{12{InstrQ101H.j.imm20}}, InstrQ101H.j.imm19_12, InstrQ101H.j.imm11,
                      InstrQ101H.j.imm10_1, 1'b0};

  // funct3 to ALU op, Alt is bit 30 of the word
  function automatic t_aluOp aluOpDecode(input logic [2:0] Funct3, input logic Alt,
                                         input logic IsReg);
    case (Funct3)
      3'b000:  return (Alt && IsReg) ? SUB : ADD; // No SUBI
      3'b001:  return SLL;
      3'b010:  return SLT;
      3'b011:  return SLTU;
      3'b100:  return XOR;
      3'b101:  return Alt ? SRA : SRL;
      3'b110:  return OR;
      default: return AND;
    endcase
  endfunction

  // ========================================
  // Control decode
  // ========================================
  always_comb begin
    SupportedQ101H = 1'b1;
    AluOpQ101H     = ADD; // Address and target adds
    IsBranchQ101H  = 1'b0;
    IsJumpQ101H    = 1'b0;
    IsJalrQ101H    = 1'b0;
    IsStoreQ101H   = 1'b0;
    LuiQ101H       = 1'b0;
    SelAluPcQ101H  = 1'b0;
    SelAluImmQ101H = 1'b1;
    RegWrEnQ101H   = 1'b1;
    ImmediateQ101H = ImmIQ101H;
    case (InstrQ101H.r.opcode)
      LUI: begin
        LuiQ101H       = 1'b1; // Immediate passes through
        ImmediateQ101H = ImmUQ101H;
      end
      AUIPC: begin
        SelAluPcQ101H  = 1'b1;
        ImmediateQ101H = ImmUQ101H;
      end
      JAL: begin
        IsJumpQ101H    = 1'b1;
        SelAluPcQ101H  = 1'b1;
        ImmediateQ101H = ImmJQ101H;
      end
      JALR: begin
        IsJumpQ101H = 1'b1;
        IsJalrQ101H = 1'b1; // rs1 + I imm
      end
      BRANCH: begin
        IsBranchQ101H  = 1'b1;
        SelAluPcQ101H  = 1'b1;
        RegWrEnQ101H   = 1'b0;
        ImmediateQ101H = ImmBQ101H;
      end
      OP_IMM: AluOpQ101H = aluOpDecode(InstrQ101H.r.funct3, InstrQ101H.r.funct7[5], 1'b0);
      OP: begin
        SelAluImmQ101H = 1'b0;
        AluOpQ101H     = aluOpDecode(InstrQ101H.r.funct3, InstrQ101H.r.funct7[5], 1'b1);
      end
      STORE: begin
        IsStoreQ101H   = 1'b1;
        RegWrEnQ101H   = 1'b0;
        ImmediateQ101H = ImmSQ101H;
      end
      default: begin
        SupportedQ101H = 1'b0; // Bubble
        RegWrEnQ101H   = 1'b0;
      end
    endcase
    if (InstrQ101H.r.rd == 5'd0) RegWrEnQ101H = 1'b0; // x0 never written
  end

  // ========================================
  // Q101H to Q102H registers
  // ========================================
  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      ValidQ102H    <= 1'b0;
      IsBranchQ102H <= 1'b0;
      IsJumpQ102H   <= 1'b0;
      IsJalrQ102H   <= 1'b0;
      IsStoreQ102H  <= 1'b0;
      RegWrEnQ102H  <= 1'b0;
    end else if (Ready) begin
      ValidQ102H    <= InstrValidQ101H && SupportedQ101H;
      IsBranchQ102H <= IsBranchQ101H;
      IsJumpQ102H   <= IsJumpQ101H;
      IsJalrQ102H   <= IsJalrQ101H;
      IsStoreQ102H  <= IsStoreQ101H;
      RegWrEnQ102H  <= RegWrEnQ101H;
    end
  end

  always_ff @(posedge Clock) begin
    if (Ready) begin
      AluOpQ102H         <= AluOpQ101H;
      BranchOpQ102H      <= t_branchOp'(InstrQ101H.b.funct3);
      LuiQ102H           <= LuiQ101H;
      SelAluPcQ102H      <= SelAluPcQ101H;
      SelAluImmQ102H     <= SelAluImmQ101H;
      RegSrc1Q102H       <= RegSrc1Q101H;
      RegSrc2Q102H       <= RegSrc2Q101H;
      RegDstQ102H        <= InstrQ101H.r.rd;
      ImmediateQ102H     <= ImmediateQ101H;
      PcQ102H            <= PcQ101H;
      PreRegRdData1Q102H <= PreRegRdData1Q101H;
      PreRegRdData2Q102H <= PreRegRdData2Q101H;
    end
  end

  // Fetch must not hand over a JALR with a reserved funct3
  aJalrFunct3: assert property (@(posedge Clock) disable iff (!arstN)
    (Ready && InstrValidQ101H && InstrQ101H.i.opcode == JALR) |-> InstrQ101H.i.funct3 == 3'b000);

endmodule

//--- miniCoreExe.sv
`timescale 1ns/1ns
// miniCore execute stage
// Forwards from Q103H and Q104H, runs the ALU and branch comparator
// Reports branches at Q102H and registers results into Q103H
module miniCoreExe
  import miniCorePkg::*;
(
  input  logic        Clock,
  input  logic        arstN,
  input  logic        Ready,
  input  logic        ValidQ102H,
  input  t_aluOp      AluOpQ102H,
  input  t_branchOp   BranchOpQ102H,
  input  logic        IsBranchQ102H,
  input  logic        IsJumpQ102H,
  input  logic        IsJalrQ102H,
  input  logic        IsStoreQ102H,
  input  logic        LuiQ102H,
  input  logic        SelAluPcQ102H,
  input  logic        SelAluImmQ102H,
  input  logic        RegWrEnQ102H,
  input  logic [4:0]  RegSrc1Q102H,
  input  logic [4:0]  RegSrc2Q102H,
  input  logic [4:0]  RegDstQ102H,
  input  logic [31:0] ImmediateQ102H,
  input  logic [31:0] PcQ102H,
  input  logic [31:0] PreRegRdData1Q102H,
  input  logic [31:0] PreRegRdData2Q102H,
  input  logic        RegWrEnQ104H,
  input  logic [4:0]  RegDstQ104H,
  input  logic [31:0] RegWrDataQ104H,
  output logic        BranchValidQ102H,
  output logic        BranchTakenQ102H,
  output logic [31:0] BranchTargetQ102H,
  output logic [31:0] ResultQ103H,
  output logic        RegWrEnQ103H,
  output logic [4:0]  RegDstQ103H,
  output logic        StoreQ103H,
  output logic [31:0] DMemWrDataQ103H
);

  logic        Hazard3Src1Q102H, Hazard4Src1Q102H, Hazard3Src2Q102H, Hazard4Src2Q102H;
  logic [31:0] RegRdData1Q102H, RegRdData2Q102H;
  logic [31:0] AluIn1Q102H, AluIn2Q102H, AluOutQ102H, ResultQ102H;
  logic        CondMetQ102H;

  // ========================================
  // Hazards and forwarding
  // ========================================
  assign Hazard3Src1Q102H = RegWrEnQ103H && (RegSrc1Q102H == RegDstQ103H) && (RegSrc1Q102H != 5'd0);
  assign Hazard4Src1Q102H = RegWrEnQ104H && (RegSrc1Q102H == RegDstQ104H) && (RegSrc1Q102H != 5'd0);
  assign Hazard3Src2Q102H = RegWrEnQ103H && (RegSrc2Q102H == RegDstQ103H) && (RegSrc2Q102H != 5'd0);
  assign Hazard4Src2Q102H = RegWrEnQ104H && (RegSrc2Q102H == RegDstQ104H) && (RegSrc2Q102H != 5'd0);

  assign RegRdData1Q102H = Hazard3Src1Q102H ? ResultQ103H    : // Youngest first
                           Hazard4Src1Q102H ? RegWrDataQ104H :
                                              PreRegRdData1Q102H;
  assign RegRdData2Q102H = Hazard3Src2Q102H ? ResultQ103H    :
                           Hazard4Src2Q102H ? RegWrDataQ104H :
                                              PreRegRdData2Q102H;

  assign AluIn1Q102H = SelAluPcQ102H  ? PcQ102H        : RegRdData1Q102H;
  assign AluIn2Q102H = SelAluImmQ102H ? ImmediateQ102H : RegRdData2Q102H;

  // ========================================
  // ALU and branch comparator
  // ========================================
  always_comb begin
    case (AluOpQ102H)
      SUB:     AluOutQ102H = AluIn1Q102H - AluIn2Q102H;
      SLT:     AluOutQ102H = {31'b0, $signed(AluIn1Q102H) < $signed(AluIn2Q102H)};
      SLTU:    AluOutQ102H = {31'b0, AluIn1Q102H < AluIn2Q102H};
      SLL:     AluOutQ102H = AluIn1Q102H << AluIn2Q102H[4:0];
      SRL:     AluOutQ102H = AluIn1Q102H >> AluIn2Q102H[4:0];
      SRA:     AluOutQ102H = $signed(AluIn1Q102H) >>> AluIn2Q102H[4:0];
      XOR:     AluOutQ102H = AluIn1Q102H ^ AluIn2Q102H;
      OR:      AluOutQ102H = AluIn1Q102H | AluIn2Q102H;
      AND:     AluOutQ102H = AluIn1Q102H & AluIn2Q102H;
      default: AluOutQ102H = AluIn1Q102H + AluIn2Q102H; // ADD, targets, addresses
    endcase
    if (LuiQ102H) AluOutQ102H = AluIn2Q102H;
  end

  always_comb begin
    case (BranchOpQ102H)
      BEQ:     CondMetQ102H = RegRdData1Q102H == RegRdData2Q102H;
      BNE:     CondMetQ102H = RegRdData1Q102H != RegRdData2Q102H;
      BLT:     CondMetQ102H = $signed(RegRdData1Q102H) < $signed(RegRdData2Q102H);
      BGE:     CondMetQ102H = $signed(RegRdData1Q102H) >= $signed(RegRdData2Q102H);
      BLTU:    CondMetQ102H = RegRdData1Q102H < RegRdData2Q102H;
      BGEU:    CondMetQ102H = RegRdData1Q102H >= RegRdData2Q102H;
      default: CondMetQ102H = 1'b0; // Reserved funct3
    endcase
  end

  assign BranchValidQ102H  = ValidQ102H && (IsBranchQ102H || IsJumpQ102H);
  assign BranchTakenQ102H  = ValidQ102H && (IsJumpQ102H || (IsBranchQ102H && CondMetQ102H));
  assign BranchTargetQ102H = IsJalrQ102H ? {AluOutQ102H[31:1], 1'b0} : AluOutQ102H;
  assign ResultQ102H       = IsJumpQ102H ? PcQ102H + 32'd4 : AluOutQ102H; // Link value

  // ========================================
  // Q102H to Q103H registers
  // ========================================
  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      RegWrEnQ103H <= 1'b0;
      StoreQ103H   <= 1'b0;
    end else if (Ready) begin
      RegWrEnQ103H <= ValidQ102H && RegWrEnQ102H;
      StoreQ103H   <= ValidQ102H && IsStoreQ102H;
    end
  end

  always_ff @(posedge Clock) begin
    if (Ready) begin
      ResultQ103H     <= ResultQ102H;
      RegDstQ103H     <= RegDstQ102H;
      DMemWrDataQ103H <= RegRdData2Q102H; // Forwarded rs2
    end
  end

  aTakenIsValid: assert property (@(posedge Clock) disable iff (!arstN)
    BranchTakenQ102H |-> BranchValidQ102H);

endmodule

//--- miniCorePkg.sv
// miniCore shared definitions
// RV32I opcodes, ALU and branch operations, instruction word formats
package miniCorePkg;

  localparam int NumRegs = 32; // x0 to x31, x0 hard-wired

  // ========================================
  // Major opcodes, supported subset only
  // ========================================
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    STORE  = 7'b0100011
  } t_opcode;

  typedef enum logic [3:0] {
    ADD, SUB, SLT, SLTU,
    SLL, SRL, SRA,
    XOR, OR, AND
  } t_aluOp;

  // Same values as funct3 of the branch word
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } t_branchOp;

  // ========================================
  // Instruction formats, MSB first
  // ========================================
  typedef struct packed {
    logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [4:0] rd;  t_opcode    opcode;
  } t_rType;

  typedef struct packed {
    logic [11:0] imm11_0; logic [4:0] rs1; logic [2:0] funct3;
    logic [4:0]  rd;      t_opcode    opcode;
  } t_iType;

  typedef struct packed {
    logic [6:0] imm11_5; logic [4:0] rs2;    logic [4:0] rs1;
    logic [2:0] funct3;  logic [4:0] imm4_0; t_opcode    opcode;
  } t_sType;

  typedef struct packed {
    logic       imm12;  logic [5:0] imm10_5; logic [4:0] rs2;   logic [4:0] rs1;
    logic [2:0] funct3; logic [3:0] imm4_1;  logic       imm11; t_opcode    opcode;
  } t_bType;

  typedef struct packed {
    logic [19:0] imm31_12; logic [4:0] rd; t_opcode opcode;
  } t_uType;

  typedef struct packed {
    logic       imm20;    logic [9:0] imm10_1; logic imm11;
    logic [7:0] imm19_12; logic [4:0] rd;      t_opcode opcode;
  } t_jType;

  // One word, six views
  typedef union packed {
    t_rType r;
    t_iType i;
    t_sType s;
    t_bType b;
    t_uType u;
    t_jType j;
  } t_instr;

endpackage

//--- miniCoreRegFile.sv
`timescale 1ns/1ns
// miniCore register file
// x1 to x31 with two read ports and one write port
// A Q104H write is bypassed to a Q101H read of the same register
module miniCoreRegFile
  import miniCorePkg::*;
(
  input  logic        Clock,
  input  logic        arstN,
  input  logic [4:0]  RegSrc1Q101H,
  input  logic [4:0]  RegSrc2Q101H,
  input  logic        RegWrEnQ104H,
  input  logic        Ready,
  input  logic [4:0]  RegDstQ104H,
  input  logic [31:0] RegWrDataQ104H,
  output logic [31:0] PreRegRdData1Q101H,
  output logic [31:0] PreRegRdData2Q101H
);

  logic [31:0] Regs [1:NumRegs-1]; // No storage for x0
  logic        WrEnQ104H;

  assign WrEnQ104H = RegWrEnQ104H && Ready && (RegDstQ104H != 5'd0);

  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < NumRegs; i++) begin
        Regs[i] <= '0;
      end
    end else if (WrEnQ104H) begin
      Regs[RegDstQ104H] <= RegWrDataQ104H;
    end
  end

  // One read port, x0 and bypass handled here
  function automatic logic [31:0] readPort(input logic [4:0] Src);
    if (Src == 5'd0) begin
      return '0;
    end
    if (WrEnQ104H && (Src == RegDstQ104H)) begin
      return RegWrDataQ104H; // Write-through
    end
    return Regs[Src];
  endfunction

  always_comb begin
    PreRegRdData1Q101H = readPort(RegSrc1Q101H);
    PreRegRdData2Q101H = readPort(RegSrc2Q101H);
  end

endmodule

//--- miniCoreResult.sv
`timescale 1ns/1ns
// miniCore result stage
// Presents stores at Q103H and registers the writeback into Q104H
module miniCoreResult
  import miniCorePkg::*;
(
  input  logic        Clock,
  input  logic        arstN,
  input  logic        Ready,
  input  logic [31:0] ResultQ103H,
  input  logic        RegWrEnQ103H,
  input  logic [4:0]  RegDstQ103H,
  input  logic        StoreQ103H,
  input  logic [31:0] StoreDataQ103H,
  output logic        DMemWrEnQ103H,
  output logic [31:0] DMemAddrQ103H,
  output logic [31:0] DMemWrDataQ103H,
  output logic        RegWrEnQ104H,
  output logic [4:0]  RegDstQ104H,
  output logic [31:0] RegWrDataQ104H
);

  // Memory writes only on an advancing cycle
  assign DMemWrEnQ103H   = StoreQ103H && Ready;
  assign DMemAddrQ103H   = ResultQ103H; // rs1 + imm
  assign DMemWrDataQ103H = StoreDataQ103H;

  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      RegWrEnQ104H <= 1'b0;
    end else if (Ready) begin
      RegWrEnQ104H <= RegWrEnQ103H;
    end
  end

  always_ff @(posedge Clock) begin
    if (Ready) begin
      RegDstQ104H    <= RegDstQ103H;
      RegWrDataQ104H <= ResultQ103H;
    end
  end

  // Decode clears rd x0, exe gates by valid
  aNoX0Write: assert property (@(posedge Clock) disable iff (!arstN)
    RegWrEnQ104H |-> RegDstQ104H != 5'd0);

  aStoreNoWrite: assert property (@(posedge Clock) disable iff (!arstN)
    StoreQ103H |-> !RegWrEnQ103H);

endmodule

//--- miniCoreTb.sv
`timescale 1ns/1ns
// miniCore testbench
// Random RV32I stream from an LCG, run in order on an architectural model
// Writebacks, stores and branch reports are compared as the DUT produces them
module miniCoreTb
  import miniCorePkg::*;
();

  localparam int          NumSlots   = 600;
  localparam int          CycleLimit = 2 * NumSlots + 100;
  localparam logic [31:0] Seed       = 32'hd3b0;

  // DUT ports
  logic        Clock, arstN, Ready, InstrValidQ101H;
  t_instr      InstrQ101H;
  logic [31:0] PcQ101H;
  logic        BranchValidQ102H, BranchTakenQ102H;
  logic [31:0] BranchTargetQ102H;
  logic        DMemWrEnQ103H;
  logic [31:0] DMemAddrQ103H, DMemWrDataQ103H;
  logic        RegWrEnQ104H;
  logic [4:0]  RegDstQ104H;
  logic [31:0] RegWrDataQ104H;

  // Model state and expected events, oldest first
  logic [31:0] lcgState = Seed;
  logic [31:0] modelRegs [NumRegs];
  logic [36:0] wbQueue [$];     // {rd, data}
  logic [63:0] storeQueue [$];  // {addr, data}
  logic [32:0] branchQueue [$]; // {taken, target}
  int          cycleCount = 0;

  // Slot being presented at Q101H
  logic [6:0]  curOp;
  logic [4:0]  curRd, curRs1, curRs2;
  logic [2:0]  curF3;
  logic        curAlt;          // SUB or SRA
  logic [31:0] curImm, curPc;
  t_instr      curWord;

  miniCore miniCore_inst (.*);

  initial begin
    Clock = 1'b0;
    forever #10 Clock = ~Clock;
  end

  // ========================================
  // Helpers
  // ========================================
  // Halves swapped, low LCG bits are weak
  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return {lcgState[15:0], lcgState[31:16]};
  endfunction

  function automatic logic [4:0] pickReg();
    logic [31:0] r;
    r = nextRandom();
    return (r[3:0] == 4'd0) ? r[8:4] : {2'b00, r[6:4]}; // Mostly x0 to x7
  endfunction

  task automatic abortRun();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] got, exp);
    $display("Error: %s got %h expected %h", name, got, exp);
    abortRun();
  endtask

  // Integer op semantics by funct3
  function automatic logic [31:0] aluResult(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, y);
    case (f3)
      3'b000:  return alt ? x - y : x + y;
      3'b001:  return x << y[4:0];
      3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'b011:  return (x < y) ? 32'd1 : 32'd0;
      3'b100:  return x ^ y;
      3'b101: begin
        if (alt) return $signed(x) >>> y[4:0];
        return x >> y[4:0];
      end
      3'b110:  return x | y;
      default: return x & y;
    endcase
  endfunction

  // ========================================
  // Stimulus
  // ========================================
  task automatic makeSlot();
    logic [31:0] r, p, sel;
    logic [2:0]  branchF3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    r      = nextRandom();
    p      = nextRandom();
    sel    = nextRandom() % 100;
    curRd  = pickReg();
    curRs1 = pickReg();
    curRs2 = pickReg();
    curF3  = r[2:0];
    curAlt = r[3];
    curImm = {{20{r[31]}}, r[31:20]}; // I and S range
    curPc  = {p[31:2], 2'b00};
    if      (sel < 8)  curOp = LUI;
    else if (sel < 14) curOp = AUIPC;
    else if (sel < 21) curOp = JAL;
    else if (sel < 28) curOp = JALR;
    else if (sel < 45) curOp = BRANCH;
    else if (sel < 67) curOp = OP_IMM;
    else if (sel < 89) curOp = OP;
    else if (sel < 97) curOp = STORE;
    else               curOp = 7'b0000011; // Load, not supported

    case (curOp)
      LUI, AUIPC: curImm = {r[31:12], 12'b0};
      JAL:        curImm = {{11{r[31]}}, r[31:12], 1'b0};
      JALR:       curF3  = 3'b000;
      STORE:      curF3  = 3'b010; // SW
      BRANCH: begin
        curImm = {{19{r[31]}}, r[31:20], 1'b0};
        curF3  = branchF3[r[2:0] % 6];
      end
      OP_IMM: begin
        if (curF3 == 3'b001 || curF3 == 3'b101) begin
          curAlt = curAlt && (curF3 == 3'b101);
          curImm = {20'b0, curAlt ? 7'h20 : 7'h00, r[24:20]}; // Shamt
        end else begin
          curAlt = 1'b0;
        end
      end
      OP: if (curF3 != 3'b000 && curF3 != 3'b101) curAlt = 1'b0;
      default: ;
    endcase

    // Assemble through the format views
    curWord = '0;
    case (curOp)
      LUI, AUIPC: begin
        curWord.u.imm31_12 = curImm[31:12];
        curWord.u.rd       = curRd;
      end
      JAL: begin
        curWord.j.imm20    = curImm[20];
        curWord.j.imm10_1  = curImm[10:1];
        curWord.j.imm11    = curImm[11];
        curWord.j.imm19_12 = curImm[19:12];
        curWord.j.rd       = curRd;
      end
      BRANCH: begin
        curWord.b.imm12   = curImm[12];
        curWord.b.imm10_5 = curImm[10:5];
        curWord.b.imm4_1  = curImm[4:1];
        curWord.b.imm11   = curImm[11];
        curWord.b.rs2     = curRs2;
        curWord.b.rs1     = curRs1;
        curWord.b.funct3  = curF3;
      end
      STORE: begin
        curWord.s.imm11_5 = curImm[11:5];
        curWord.s.imm4_0  = curImm[4:0];
        curWord.s.rs2     = curRs2;
        curWord.s.rs1     = curRs1;
        curWord.s.funct3  = curF3;
      end
      OP: begin
        curWord.r.funct7 = curAlt ? 7'h20 : 7'h00;
        curWord.r.rs2    = curRs2;
        curWord.r.rs1    = curRs1;
        curWord.r.funct3 = curF3;
        curWord.r.rd     = curRd;
      end
      default: begin // JALR, OP-IMM and the load
        curWord.i.imm11_0 = curImm[11:0];
        curWord.i.rs1     = curRs1;
        curWord.i.funct3  = curF3;
        curWord.i.rd      = curRd;
      end
    endcase
    curWord[6:0] = curOp;
  endtask

  // ========================================
  // Architectural model
  // ========================================
  task automatic writeReg(input logic [4:0] rd, input logic [31:0] value);
    if (rd != 5'd0) begin
      modelRegs[rd] = value;
      wbQueue.push_back({rd, value});
    end
  endtask

  task automatic runModel();
    logic [31:0] a, b;
    logic        taken;
    a = modelRegs[curRs1];
    b = modelRegs[curRs2];
    case (curOp)
      LUI:   writeReg(curRd, curImm);
      AUIPC: writeReg(curRd, curPc + curImm);
      JAL: begin
        branchQueue.push_back({1'b1, curPc + curImm});
        writeReg(curRd, curPc + 32'd4);
      end
      JALR: begin
        branchQueue.push_back({1'b1, (a + curImm) & ~32'd1}); // Target read before link
        writeReg(curRd, curPc + 32'd4);
      end
      BRANCH: begin
        case (curF3)
          3'b000:  taken = a == b;
          3'b001:  taken = a != b;
          3'b100:  taken = $signed(a) < $signed(b);
          3'b101:  taken = $signed(a) >= $signed(b);
          3'b110:  taken = a < b;
          default: taken = a >= b;
        endcase
        branchQueue.push_back({taken, curPc + curImm});
      end
      OP_IMM: writeReg(curRd, aluResult(curF3, curAlt, a, curImm));
      OP:     writeReg(curRd, aluResult(curF3, curAlt, a, b));
      STORE:  storeQueue.push_back({a + curImm, b});
      default: ; // Bubble
    endcase
  endtask

  task automatic driveSlot();
    logic [31:0] r;
    makeSlot();
    r               = nextRandom();
    Ready           = (r % 5) != 0;     // Stall about one cycle in five
    InstrValidQ101H = r[31:29] != 3'd0; // Fetch gaps
    InstrQ101H      = curWord;
    PcQ101H         = curPc;
    if (Ready && InstrValidQ101H) runModel();
  endtask

  // ========================================
  // Event checks, mid-cycle
  // ========================================
  task automatic checkEvents();
    logic [36:0] wb;
    logic [63:0] st;
    logic [32:0] br;
    if (!Ready) begin
      assert (!DMemWrEnQ103H) else begin
        $display("Store strobe active while Ready is low");
        abortRun();
      end
    end else begin
      if (RegWrEnQ104H) begin
        assert (wbQueue.size() != 0) else begin
          $display("Writeback to x%0d when none was expected", RegDstQ104H);
          abortRun();
        end
        wb = wbQueue.pop_front();
        assert (RegDstQ104H == wb[36:32])
          else reportMismatch("RegDstQ104H", RegDstQ104H, wb[36:32]);
        assert (RegWrDataQ104H == wb[31:0])
          else reportMismatch("RegWrDataQ104H", RegWrDataQ104H, wb[31:0]);
      end
      if (DMemWrEnQ103H) begin
        assert (storeQueue.size() != 0) else begin
          $display("Store issued when none was expected");
          abortRun();
        end
        st = storeQueue.pop_front();
        assert (DMemAddrQ103H == st[63:32])
          else reportMismatch("DMemAddrQ103H", DMemAddrQ103H, st[63:32]);
        assert (DMemWrDataQ103H == st[31:0])
          else reportMismatch("DMemWrDataQ103H", DMemWrDataQ103H, st[31:0]);
      end
      if (BranchValidQ102H) begin
        assert (branchQueue.size() != 0) else begin
          $display("Branch report from an instruction that is not a branch or jump");
          abortRun();
        end
        br = branchQueue.pop_front();
        assert (BranchTakenQ102H == br[32])
          else reportMismatch("BranchTakenQ102H", BranchTakenQ102H, br[32]);
        assert (BranchTargetQ102H == br[31:0])
          else reportMismatch("BranchTargetQ102H", BranchTargetQ102H, br[31:0]);
      end
    end
  endtask

  always @(negedge Clock) begin
    if (arstN) begin
      checkEvents();
    end else begin
      assert (!(RegWrEnQ104H || DMemWrEnQ103H || BranchValidQ102H)) else begin
        $display("Event strobe active during reset");
        abortRun();
      end
    end
  end

  always @(posedge Clock) begin
    cycleCount = cycleCount + 1;
    assert (cycleCount < CycleLimit) else begin
      $display("Timeout, run still going after %0d cycles", CycleLimit);
      abortRun();
    end
  end

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    arstN           = 1'b0;
    Ready           = 1'b0;
    InstrValidQ101H = 1'b0;
    InstrQ101H      = '0;
    PcQ101H         = '0;
    for (int i = 0; i < NumRegs; i++) begin
      modelRegs[i] = '0;
    end
    repeat (10) @(posedge Clock);
    #2 arstN = 1'b1;

    for (int slot = 0; slot < NumSlots; slot++) begin
      @(posedge Clock);
      #2;
      driveSlot();
    end

    // Drain, last event is three advancing edges after acceptance
    for (int d = 0; d < 4; d++) begin
      @(posedge Clock);
      #2;
      Ready           = 1'b1;
      InstrValidQ101H = 1'b0;
    end
    @(negedge Clock);
    #1;
    assert (wbQueue.size() + storeQueue.size() + branchQueue.size() == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Missing events: %0d writebacks, %0d stores, %0d branch reports",
               wbQueue.size(), storeQueue.size(), branchQueue.size());
      abortRun();
    end
  end

endmodule
